// ==== softmax_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared softmax definitions: Q16.16 format constants, tile and
// buffer-port structs, engine FSM state encoding
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package softmax_pkg;

    // Internal fixed-point format
    localparam int q_width = 32;
    localparam int q_frac  = 16;

    typedef logic signed [q_width-1:0] q_t;

    localparam q_t ln2_q   = 32'sh0000_B172;  // 0.693147
    localparam q_t log2e_q = 32'sh0001_7154;  // 1.442695
    localparam q_t q_min   = 32'sh8000_0000;  // Most negative value

    // Upper bound on lanes per tile so the structs keep a fixed size
    localparam int max_tile_size = 16;

    // Buffer word address width, enough for 256 tiles
    localparam int buf_aw = 8;

    // Element 0 sits in the most significant chunk
    typedef q_t [0:max_tile_size-1] tile_t;

    // Loader to buffer write port
    typedef struct packed {
        logic              we;
        logic [buf_aw-1:0] addr;
        tile_t             data;
    } buf_wr_t;

    // Loader to engine handoff
    typedef struct packed {
        logic done;  // One-cycle pulse after the last tile write
        q_t   max;   // Max over all active lanes
    } load_info_t;

    typedef enum logic [2:0] {
        st_idle,
        st_sum,   // exp(x - max) and accumulate
        st_ln,    // Latch ln(sum)
        st_out,   // Stream exp(x - max - ln sum)
        st_done
    } engine_state_e;

endpackage

`default_nettype wire

// ==== tile_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile loader: input format to Q16.16, buffer writes, running max
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tile_loader #(
    parameter int WIDTH          = 16,
    parameter int FRAC_WIDTH     = 8,
    parameter int TOTAL_ELEMENTS = 36,
    parameter int TILE_SIZE      = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic                       tile_in_valid,
    input  logic [TILE_SIZE*WIDTH-1:0] tile_in,
    output softmax_pkg::buf_wr_t       wr,
    output softmax_pkg::load_info_t    load_info
);
    localparam int N_TILES    = (TOTAL_ELEMENTS + TILE_SIZE - 1) / TILE_SIZE;
    localparam int LAST_LANES = TOTAL_ELEMENTS - (N_TILES - 1) * TILE_SIZE;
    localparam int CW         = $clog2(N_TILES + 1);

    logic                active;   // Between start and the last tile
    logic [CW-1:0]       tile_cnt;
    logic                last_tile;
    logic                accept;
    logic                done_q;
    softmax_pkg::q_t     max_q;
    softmax_pkg::q_t     tile_max;
    softmax_pkg::tile_t  conv;

    function automatic softmax_pkg::q_t to_q(input logic signed [WIDTH-1:0] v);
        softmax_pkg::q_t ext;
        ext = softmax_pkg::q_t'(v);  // Sign extension
        if (FRAC_WIDTH <= softmax_pkg::q_frac)
            return ext <<< (softmax_pkg::q_frac - FRAC_WIDTH);
        else
            return ext >>> (FRAC_WIDTH - softmax_pkg::q_frac);
    endfunction

    assign accept    = tile_in_valid && active;
    assign last_tile = (tile_cnt == CW'(N_TILES - 1));

    // Convert lanes and fold this tile into the max, skipping padding
    always_comb begin
        conv     = '0;
        tile_max = max_q;
        for (int i = 0; i < TILE_SIZE; i++) begin
            conv[i] = to_q(tile_in[(TILE_SIZE-1-i)*WIDTH +: WIDTH]);
            if ((!last_tile || i < LAST_LANES) && conv[i] > tile_max)
                tile_max = conv[i];
        end
    end

    assign wr.we   = accept;
    assign wr.addr = softmax_pkg::buf_aw'(tile_cnt);
    assign wr.data = conv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            tile_cnt <= '0;
            max_q    <= softmax_pkg::q_min;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start) begin
                active   <= 1'b1;
                tile_cnt <= '0;
                max_q    <= softmax_pkg::q_min;
            end else if (accept) begin
                max_q    <= tile_max;
                tile_cnt <= tile_cnt + 1'b1;
                if (last_tile) begin
                    active <= 1'b0;
                    done_q <= 1'b1;  // Max is final from this pulse on
                end
            end
        end
    end

    assign load_info.done = done_q;
    assign load_info.max  = max_q;

    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr.we |-> wr.addr < N_TILES);

endmodule

`default_nettype wire

// ==== tile_buffer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile buffer, one write and one registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tile_buffer #(
    parameter int DEPTH = 5
) (
    input  logic                                 clk,
    input  softmax_pkg::buf_wr_t                 wr,
    input  logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0] rd_addr,
    output softmax_pkg::tile_t                   rd_data
);
    localparam int AW = $clog2(DEPTH > 1 ? DEPTH : 2);

    softmax_pkg::tile_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.we)
            mem[wr.addr[AW-1:0]] <= wr.data;
        rd_data <= mem[rd_addr];  // One cycle read latency
    end

    // Upper address bits are dropped above, so they must be clear
    a_wr_addr: assert property (@(posedge clk)
        wr.we |-> wr.addr < DEPTH);

endmodule

`default_nettype wire

// ==== exp_tile.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Lane-parallel registered exp() for non-positive Q16.16 inputs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module exp_tile (
    input  logic               clk,
    input  softmax_pkg::tile_t x,
    output softmax_pkg::tile_t y
);
    // 2^-f ~ 1 - 0.67 f + 0.17 f^2 on [0, 1)
    localparam logic [31:0] C_LIN  = 32'd43909;
    localparam logic [31:0] C_QUAD = 32'd11141;
    localparam logic [31:0] ONE_Q  = 32'd65536;

    localparam softmax_pkg::q_t X_FLOOR = -(32'sd16 <<< softmax_pkg::q_frac);

    function automatic softmax_pkg::q_t exp_lane(input softmax_pkg::q_t xin);
        logic signed [63:0] prod;
        logic        [31:0] t;
        logic        [15:0] f;
        logic        [31:0] f2;
        logic        [31:0] lin;
        logic        [31:0] quad;
        logic        [31:0] mant;
        prod = xin * softmax_pkg::log2e_q;         // Q32.32
        t    = 32'(-(prod >>> softmax_pkg::q_frac)); // x*log2e as positive Q16.16
        f    = t[15:0];
        f2   = (f * f) >> 16;
        lin  = (C_LIN * f) >> 16;
        quad = (C_QUAD * f2) >> 16;
        mant = ONE_Q - lin + quad;                  // 2^-f in (0.5, 1]
        if (xin < X_FLOOR)
            return '0;
        // Integer part is at most 23 here
        return softmax_pkg::q_t'(mant >> t[20:16]);
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < softmax_pkg::max_tile_size; i++)
            y[i] <= exp_lane(x[i]);
    end

    function automatic logic all_nonpos(input softmax_pkg::tile_t v);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < softmax_pkg::max_tile_size; i++)
            if (v[i] > 0)
                ok = 1'b0;
        return ok;
    endfunction

    // Engine masks idle and padded lanes, so every lane holds
    a_nonpos_in: assert property (@(posedge clk) all_nonpos(x));

endmodule

`default_nettype wire

// ==== ln_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational natural log of the wide exp sum
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ln_unit #(
    parameter int TOTAL_ELEMENTS = 36
) (
    input  logic [softmax_pkg::q_width+$clog2(TOTAL_ELEMENTS+1)-1:0] sum,
    output softmax_pkg::q_t                                        ln
);
    localparam int SW = softmax_pkg::q_width + $clog2(TOTAL_ELEMENTS + 1);
    localparam int QF = softmax_pkg::q_frac;

    // ln(1+v) ~ c0 + c1 v + c2 v^2 for v in [-0.25, 0.5)
    localparam logic signed [63:0] C0 = -64'sd281;
    localparam logic signed [63:0] C1 = 64'sd67429;
    localparam logic signed [63:0] C2 = -64'sd27443;

    int                 lead;
    int                 ex;
    logic [SW-1:0]      norm;
    logic signed [63:0] v;
    logic signed [63:0] vsq;
    logic signed [63:0] acc;

    always_comb begin
        lead = 0;
        for (int i = 0; i < SW; i++)
            if (sum[i])
                lead = i;
        // Mantissa lands in [1, 2) with the leading one at bit QF
        if (lead >= QF)
            norm = sum >> (lead - QF);
        else
            norm = sum << (QF - lead);
        ex = lead - QF;
        if (norm[QF-1]) begin  // m >= 1.5, halve it
            v  = 64'(norm[QF:1]) - 64'sd65536;
            ex = ex + 1;
        end else begin
            v = 64'(norm[QF-1:0]);
        end
        vsq = (v * v) >>> QF;
        acc = ex * softmax_pkg::ln2_q;
        acc = acc + C0 + ((C1 * v) >>> QF) + ((C2 * vsq) >>> QF);
        ln  = softmax_pkg::q_t'(acc);
    end

endmodule

`default_nettype wire

// ==== softmax_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax engine: pass FSM, read pipeline, exp sum, output stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module softmax_engine #(
    parameter int WIDTH          = 16,
    parameter int FRAC_WIDTH     = 8,
    parameter int TOTAL_ELEMENTS = 36,
    parameter int TILE_SIZE      = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  softmax_pkg::load_info_t    load_info,
    output logic [$clog2((TOTAL_ELEMENTS+TILE_SIZE-1)/TILE_SIZE > 1 ?
                         (TOTAL_ELEMENTS+TILE_SIZE-1)/TILE_SIZE : 2)-1:0] rd_addr,
    input  softmax_pkg::tile_t         rd_data,
    output logic [TILE_SIZE*WIDTH-1:0] tile_out,
    output logic                       tile_out_valid,
    output logic                       done
);
    localparam int N_TILES    = (TOTAL_ELEMENTS + TILE_SIZE - 1) / TILE_SIZE;
    localparam int LAST_LANES = TOTAL_ELEMENTS - (N_TILES - 1) * TILE_SIZE;
    localparam int AW         = $clog2(N_TILES > 1 ? N_TILES : 2);
    localparam int CYW        = $clog2(N_TILES + 2);
    localparam int SW         = softmax_pkg::q_width + $clog2(TOTAL_ELEMENTS + 1);
    localparam int QF         = softmax_pkg::q_frac;

    softmax_pkg::engine_state_e state;
    logic [CYW-1:0]     cyc;
    logic               issue;
    logic               v1, v2;   // Read data valid, exp output valid
    logic               p1, p2;   // Output pass flags along the pipe
    logic [AW-1:0]      t1, t2;   // Tile index along the pipe
    softmax_pkg::tile_t sub;
    softmax_pkg::tile_t exp_y;
    logic [SW-1:0]      sum_acc;
    logic [SW-1:0]      tile_sum;
    softmax_pkg::q_t    ln_w;
    softmax_pkg::q_t    ln_q;

    function automatic logic lane_on(input int lane, input logic [AW-1:0] t);
        return lane < TILE_SIZE && (t != AW'(N_TILES - 1) || lane < LAST_LANES);
    endfunction

    // Read 0 goes out in the load done cycle itself
    assign issue = (state == softmax_pkg::st_idle && load_info.done) ||
                   ((state == softmax_pkg::st_sum || state == softmax_pkg::st_out) &&
                    cyc < CYW'(N_TILES));
    assign rd_addr = (state == softmax_pkg::st_idle) ? '0 : cyc[AW-1:0];

    // Subtract stage, padding forced far negative so exp gives zero
    always_comb begin
        for (int i = 0; i < softmax_pkg::max_tile_size; i++) begin
            if (v1 && lane_on(i, t1))
                sub[i] = p1 ? rd_data[i] - load_info.max - ln_q
                            : rd_data[i] - load_info.max;
            else
                sub[i] = softmax_pkg::q_min;
        end
    end

    exp_tile u_exp (
        .clk (clk),
        .x   (sub),
        .y   (exp_y)
    );

    ln_unit #(.TOTAL_ELEMENTS(TOTAL_ELEMENTS)) u_ln (
        .sum (sum_acc),
        .ln  (ln_w)
    );

    always_comb begin
        tile_sum = '0;
        tile_out = '0;
        for (int i = 0; i < TILE_SIZE; i++) begin
            if (lane_on(i, t2)) begin
                tile_sum = tile_sum + SW'(exp_y[i]);  // exp output is never negative
                tile_out[(TILE_SIZE-1-i)*WIDTH +: WIDTH] = WIDTH'(exp_y[i] >>> (QF - FRAC_WIDTH));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= softmax_pkg::st_idle;
            cyc   <= '0;
            v1    <= 1'b0;
            v2    <= 1'b0;
            p1    <= 1'b0;
            p2    <= 1'b0;
        end else begin
            v1 <= issue;
            p1 <= (state == softmax_pkg::st_out);
            v2 <= v1;
            p2 <= p1;
            case (state)
                softmax_pkg::st_idle: if (load_info.done) begin
                    state <= softmax_pkg::st_sum;
                    cyc   <= CYW'(1);
                end
                softmax_pkg::st_sum: begin
                    cyc <= cyc + 1'b1;
                    if (cyc == CYW'(N_TILES + 1))  // Last exp tile added here
                        state <= softmax_pkg::st_ln;
                end
                softmax_pkg::st_ln: begin
                    cyc   <= '0;
                    state <= softmax_pkg::st_out;
                end
                softmax_pkg::st_out: begin
                    cyc <= cyc + 1'b1;
                    if (cyc == CYW'(N_TILES + 1))
                        state <= softmax_pkg::st_done;
                end
                default: state <= softmax_pkg::st_idle;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        t1 <= rd_addr;
        t2 <= t1;
        if (state == softmax_pkg::st_idle && load_info.done)
            sum_acc <= '0;
        else if (state == softmax_pkg::st_sum && v2)
            sum_acc <= sum_acc + tile_sum;
        if (state == softmax_pkg::st_ln)
            ln_q <= ln_w;
    end

    assign tile_out_valid = v2 && p2;
    assign done           = (state == softmax_pkg::st_done);

    a_done_after_out: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> !tile_out_valid && $past(tile_out_valid));

endmodule

`default_nettype wire

// ==== softmax_vec.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax top: loader, tile buffer and engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module softmax_vec #(
    parameter int WIDTH          = 16,
    parameter int FRAC_WIDTH     = 8,
    parameter int TOTAL_ELEMENTS = 36,
    parameter int TILE_SIZE      = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       start,
    input  logic [TILE_SIZE*WIDTH-1:0] tile_in,
    input  logic                       tile_in_valid,
    output logic [TILE_SIZE*WIDTH-1:0] tile_out,
    output logic                       tile_out_valid,
    output logic                       done
);
    localparam int N_TILES = (TOTAL_ELEMENTS + TILE_SIZE - 1) / TILE_SIZE;
    localparam int AW      = $clog2(N_TILES > 1 ? N_TILES : 2);

    softmax_pkg::buf_wr_t    wr;
    softmax_pkg::load_info_t load_info;
    logic [AW-1:0]           rd_addr;
    softmax_pkg::tile_t      rd_data;

    tile_loader #(
        .WIDTH(WIDTH), .FRAC_WIDTH(FRAC_WIDTH),
        .TOTAL_ELEMENTS(TOTAL_ELEMENTS), .TILE_SIZE(TILE_SIZE)
    ) u_loader (
        .clk(clk), .rst_n(rst_n), .start(start), .tile_in_valid(tile_in_valid),
        .tile_in(tile_in), .wr(wr), .load_info(load_info)
    );

    tile_buffer #(.DEPTH(N_TILES)) u_buffer (
        .clk(clk), .wr(wr), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    softmax_engine #(
        .WIDTH(WIDTH), .FRAC_WIDTH(FRAC_WIDTH),
        .TOTAL_ELEMENTS(TOTAL_ELEMENTS), .TILE_SIZE(TILE_SIZE)
    ) u_engine (
        .clk(clk), .rst_n(rst_n), .load_info(load_info), .rd_addr(rd_addr),
        .rd_data(rd_data), .tile_out(tile_out), .tile_out_valid(tile_out_valid),
        .done(done)
    );

endmodule

`default_nettype wire

// ==== softmax_tb_cases.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax test cases: pattern kinds, named case table and the
// generator of quantized input elements
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOFTMAX_TB_CASES_SVH
`define SOFTMAX_TB_CASES_SVH

typedef enum int {
    pat_equal,     // Every element the same
    pat_ramp,      // Steps of 0.125 around zero
    pat_random,    // Uniform in +-4.0
    pat_spike,     // One element far above the rest
    pat_negative   // Everything well below zero
} pattern_e;

// Padded lanes carry a large value that has to stay out of the max
localparam logic signed [width-1:0] pad_value = 16'sh6400;

string    case_name [$];
pattern_e case_kind [$];
int       case_gap  [$];

task automatic add_case(input string name, input pattern_e kind, input int gap);
    case_name.push_back(name);
    case_kind.push_back(kind);
    case_gap.push_back(gap);
endtask

// Name, pattern, idle cycles between tiles
task automatic fill_cases();
    add_case("equal_back_to_back",    pat_equal,    0);
    add_case("ramp_back_to_back",     pat_ramp,     0);
    add_case("random_gap_2",          pat_random,   2);
    add_case("spike_gap_1",           pat_spike,    1);
    add_case("negative_back_to_back", pat_negative, 0);
    add_case("random_gap_5",          pat_random,   5);
    add_case("ramp_gap_3",            pat_ramp,     3);
endtask

// One Q8.8 input element of a pattern
function automatic logic signed [width-1:0] pattern_value(input pattern_e kind, input int idx);
    case (kind)
        pat_equal:  return 16'sh0180;                            // 1.5
        pat_ramp:   return width'((idx - 18) * 32);
        pat_random: return width'(int'($urandom_range(2048)) - 1024);
        pat_spike:  return (idx == 33) ? 16'sh0600 : 16'sh0000;  // 6.0 inside the last tile
        default:    return width'(idx * 128 - 24576);            // From -96.0 upward
    endcase
endfunction

`endif

// ==== softmax_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Softmax testbench with clock, reset, tile driver, output monitor,
// real-number reference checks and cycle limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module softmax_tb;
    localparam int  width          = 16;
    localparam int  frac_width     = 8;
    localparam int  total_elements = 36;
    localparam int  tile_size      = 8;
    localparam int  n_tiles        = (total_elements + tile_size - 1) / tile_size;
    localparam int  reset_cycles   = 10;
    localparam int  idle_cycles    = 2 * n_tiles + 10;
    localparam real lsb            = 1.0 / (2.0 ** frac_width);

    logic                       clk;
    logic                       rst_n;
    logic                       start;
    logic [tile_size*width-1:0] tile_in;
    logic                       tile_in_valid;
    logic [tile_size*width-1:0] tile_out;
    logic                       tile_out_valid;
    logic                       done;

    logic signed [width-1:0] in_q [total_elements];  // Inputs of the running case
    real   got [total_elements];
    string cur_name;
    bit    in_case;
    bit    case_done;
    bit    prev_valid;
    int    out_cnt;
    int    value_errors = 0;
    int    pad_errors = 0;
    int    proto_errors = 0;
    int    cycle_limit = 0;
    int    cycle_cnt;

    `include "softmax_tb_cases.svh"

    softmax_vec softmax_vec_i (
        .clk(clk), .rst_n(rst_n), .start(start), .tile_in(tile_in),
        .tile_in_valid(tile_in_valid), .tile_out(tile_out),
        .tile_out_valid(tile_out_valid), .done(done)
    );

    always #10 clk = ~clk;

    function automatic real to_real(input logic signed [width-1:0] v);
        return real'(v) * lsb;
    endfunction

    function automatic real abs_diff(input real a, input real b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic logic [tile_size*width-1:0] pack_tile(input int t);
        logic [tile_size*width-1:0] bits;
        int e;
        bits = '0;
        for (int l = 0; l < tile_size; l++) begin
            e = t * tile_size + l;
            bits[(tile_size-1-l)*width +: width] = (e < total_elements) ? in_q[e] : pad_value;
        end
        return bits;
    endfunction

    // Output monitor sampled away from the driving edge
    always @(negedge clk) begin : monitor
        int e;
        logic signed [width-1:0] lane_val;
        if (rst_n) begin
            if (start) begin
                in_case   = 1'b1;
                case_done = 1'b0;
                out_cnt   = 0;
                for (int i = 0; i < total_elements; i++)
                    got[i] = -1.0;  // Marks elements never delivered
            end
            if (tile_out_valid && !in_case) begin
                proto_errors++;
                $display("Failure: output tile strobed while no case was running");
            end else if (tile_out_valid) begin
                for (int l = 0; l < tile_size && out_cnt < n_tiles; l++) begin
                    e = out_cnt * tile_size + l;
                    lane_val = tile_out[(tile_size-1-l)*width +: width];
                    if (e < total_elements) begin
                        got[e] = to_real(lane_val);
                    end else if (lane_val != 0) begin
                        pad_errors++;
                        $display("Error %s pad lane %0d: expected 0, actual %0d",
                                 cur_name, l, lane_val);
                    end
                end
                out_cnt++;
            end
            if (done && !in_case) begin
                proto_errors++;
                $display("Failure: done pulsed while no case was running");
            end else if (done) begin
                if (out_cnt != n_tiles) begin
                    proto_errors++;
                    $display("Failure in %s: %0d output tiles before done, wanted %0d",
                             cur_name, out_cnt, n_tiles);
                end
                if (!prev_valid || tile_out_valid) begin
                    proto_errors++;
                    $display("Failure in %s: done did not follow the last output tile",
                             cur_name);
                end
                in_case   = 1'b0;
                case_done = 1'b1;
            end
            prev_valid = tile_out_valid;
        end
    end

    // Reference softmax in real arithmetic from the quantized inputs
    task automatic check_case(input int c);
        real mx;
        real s;
        real p;
        real out_sum;
        real target;
        mx      = -1.0e9;
        s       = 0.0;
        out_sum = 0.0;
        target  = 1.0;
        for (int e = 0; e < total_elements; e++)
            if (to_real(in_q[e]) > mx)
                mx = to_real(in_q[e]);
        for (int e = 0; e < total_elements; e++)
            s += $exp(to_real(in_q[e]) - mx);
        for (int e = 0; e < total_elements; e++) begin
            p = $exp(to_real(in_q[e]) - mx) / s;
            out_sum += got[e];
            target  -= p - $floor(p / lsb) * lsb;  // Each output is floored to one LSB
            if (abs_diff(got[e], p) > 0.02) begin
                value_errors++;
                $display("Error %s element %0d: expected %.5f, actual %.5f",
                         case_name[c], e, p, got[e]);
            end
            if (case_kind[c] == pat_equal && abs_diff(got[e], 1.0 / total_elements) > 0.01) begin
                value_errors++;
                $display("Error %s uniform element %0d: expected %.5f, actual %.5f",
                         case_name[c], e, 1.0 / total_elements, got[e]);
            end
        end
        if (abs_diff(out_sum, target) > 0.03) begin
            value_errors++;
            $display("Error %s output sum: expected %.5f, actual %.5f",
                     case_name[c], target, out_sum);
        end
    endtask

    initial begin : driver
        int max_gap;
        void'($urandom(32'h4521cb9d));
        fill_cases();
        max_gap = 0;
        foreach (case_gap[i])
            if (case_gap[i] > max_gap)
                max_gap = case_gap[i];
        cycle_limit = 2 * (case_name.size() * n_tiles * (max_gap + 1)
                           + case_name.size() * (n_tiles + 10))
                      + reset_cycles + idle_cycles + 10;
        clk           = 1'b0;
        rst_n         = 1'b0;
        start         = 1'b0;
        tile_in       = '0;
        tile_in_valid = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // A full load of stray tiles with no start ahead of them must be ignored
        for (int t = 0; t < n_tiles; t++) begin
            @(posedge clk);
            tile_in       <= {tile_size{16'h0100}};
            tile_in_valid <= 1'b1;
        end
        @(posedge clk);
        tile_in_valid <= 1'b0;
        repeat (idle_cycles) @(posedge clk);

        for (int c = 0; c < case_name.size(); c++) begin
            cur_name = case_name[c];
            for (int e = 0; e < total_elements; e++)
                in_q[e] = pattern_value(case_kind[c], e);
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
            for (int t = 0; t < n_tiles; t++) begin
                tile_in       <= pack_tile(t);
                tile_in_valid <= 1'b1;
                @(posedge clk);
                if (case_gap[c] > 0) begin
                    tile_in_valid <= 1'b0;
                    repeat (case_gap[c]) @(posedge clk);
                end
            end
            tile_in_valid <= 1'b0;
            wait (case_done);
            check_case(c);
        end

        $display("Summary: %0d value errors, %0d pad lane errors, %0d protocol errors",
                 value_errors, pad_errors, proto_errors);
        if (value_errors + pad_errors + proto_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    initial begin : watchdog
        wait (cycle_limit > 0);
        cycle_cnt = 0;
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still busy after %0d cycles", cycle_limit);
        $display("Summary: %0d value errors, %0d pad lane errors, %0d protocol errors",
                 value_errors, pad_errors, proto_errors + 1);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== softmax_vec.f ====
+incdir+.
softmax_pkg.sv
tile_loader.sv
tile_buffer.sv
exp_tile.sv
ln_unit.sv
softmax_engine.sv
softmax_vec.sv
softmax_tb.sv

// ==== Makefile ====
# Verilator simulation of the softmax testbench

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal -f softmax_vec.f --top-module softmax_tb -o softmax_sim
	@out=$$(./obj_dir/softmax_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
